// ==== Makefile ====
VERILATOR ?= verilator
TOP       := branch_predictor_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/bp_pkg.sv ====
`default_nettype none

`include "bp_settings.svh"

package bp_pkg;

    typedef logic [`BP_XLEN-1:0] word_t;

    typedef logic [`BP_HISTORY_DEPTH-1:0] history_t;

    typedef enum logic [1:0] {
        br   = 2'b00,
        jal  = 2'b01,
        jalr = 2'b10
    } cf_kind_t;

    // everything fetch learns about one pc
    typedef struct packed {
        logic     btb_hit;
        cf_kind_t kind;
        word_t    target;
        logic     taken;        // chosen direction
        logic     local_pr;
        logic     global_pr;
        history_t global_index; // ghr value seen at fetch
        history_t local_index;  // local history seen at fetch
        word_t    next_pc;
    } prediction_t;

    // resolved instruction, carries back its fetch prediction
    typedef struct packed {
        logic        valid;
        word_t       pc;
        cf_kind_t    kind;
        logic        taken;
        word_t       target;
        prediction_t pred;
    } resolve_t;

    typedef struct packed {
        logic [`BP_PERF_WIDTH-1:0] control_flow_count;
        logic                      control_flow_overflow;
        logic [`BP_PERF_WIDTH-1:0] correct_count;
        logic                      correct_overflow;
    } perf_stats_t;

endpackage

`default_nettype wire

// ==== logic/bp_settings.svh ====
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// address and target width
`define BP_XLEN 32

// global and local history bits, also the direction table index width
`define BP_HISTORY_DEPTH 4

// local history table index, from pc bits above the low two
`define BP_BHT_INDEX 4

// chooser table index, same pc slice
`define BP_CHOOSER_INDEX 4

// btb index bits, tag is the pc bits above them
`define BP_BTB_INDEX 3

// statistics counter width, small enough to wrap in simulation
`define BP_PERF_WIDTH 8

`endif

// ==== logic/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  wire                     clk,
    input  wire                     reset,
    input  wire bp_pkg::word_t      fetch_pc,
    input  wire bp_pkg::resolve_t   resolve,
    output bp_pkg::prediction_t     prediction,
    output bp_pkg::perf_stats_t     stats
);

    logic             btb_hit;
    bp_pkg::cf_kind_t btb_kind;
    bp_pkg::word_t    btb_target;
    logic             taken;
    logic             local_pr;
    logic             global_pr;
    bp_pkg::history_t global_index;
    bp_pkg::history_t local_index;
    logic             redirect;

    branch_target_buffer btb (
        .clk(clk),
        .reset(reset),
        .read_pc(fetch_pc),
        .resolve(resolve),
        .hit(btb_hit),
        .kind(btb_kind),
        .target(btb_target)
    );

    tournament_predictor direction (
        .clk(clk),
        .reset(reset),
        .fetch_pc(fetch_pc),
        .resolve(resolve),
        .taken(taken),
        .local_pr(local_pr),
        .global_pr(global_pr),
        .global_index(global_index),
        .local_index(local_index)
    );

    prediction_stats stats_unit (
        .clk(clk),
        .reset(reset),
        .resolve(resolve),
        .stats(stats)
    );

    // jumps always redirect, branches only when predicted taken
    assign redirect = btb_hit && ((btb_kind == bp_pkg::jal)
                               || (btb_kind == bp_pkg::jalr)
                               || (btb_kind == bp_pkg::br && taken));

    always_comb begin
        prediction.btb_hit      = btb_hit;
        prediction.kind         = btb_kind;
        prediction.target       = btb_target;
        prediction.taken        = taken;
        prediction.local_pr     = local_pr;
        prediction.global_pr    = global_pr;
        prediction.global_index = global_index;
        prediction.local_index  = local_index;
        prediction.next_pc      = redirect ? btb_target
                                           : fetch_pc + bp_pkg::word_t'(4); // sequential fetch
    end

endmodule

`default_nettype wire

// ==== logic/branch_target_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module branch_target_buffer (
    input  wire                   clk,
    input  wire                   reset,
    input  wire bp_pkg::word_t    read_pc,
    input  wire bp_pkg::resolve_t resolve,
    output logic                  hit,
    output bp_pkg::cf_kind_t      kind,
    output bp_pkg::word_t         target
);

    localparam int entries   = 2 ** `BP_BTB_INDEX;
    localparam int tag_width = `BP_XLEN - `BP_BTB_INDEX - 2;

    typedef struct packed {
        logic [tag_width-1:0] tag;
        bp_pkg::cf_kind_t     kind;
        bp_pkg::word_t        target;
    } btb_entry_t;

    logic [entries-1:0] valid;
    btb_entry_t         store [entries];

    logic [`BP_BTB_INDEX-1:0] rindex;
    logic [`BP_BTB_INDEX-1:0] windex;
    btb_entry_t               rentry;
    btb_entry_t               wentry;

    assign rindex = read_pc[`BP_BTB_INDEX+1:2];
    assign windex = resolve.pc[`BP_BTB_INDEX+1:2];
    assign rentry = store[rindex];

    always_comb begin
        wentry.tag    = resolve.pc[`BP_XLEN-1:`BP_BTB_INDEX+2];
        wentry.kind   = resolve.kind;
        wentry.target = resolve.target;
        if (resolve.kind == bp_pkg::jalr) begin
            wentry.target[0] = 1'b0; // jalr drops the low bit
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (resolve.valid) begin
            valid[windex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resolve.valid) begin
            store[windex] <= wentry; // last writer wins the slot
        end
    end

    assign hit    = valid[rindex] && (rentry.tag == read_pc[`BP_XLEN-1:`BP_BTB_INDEX+2]);
    assign kind   = rentry.kind;
    assign target = rentry.target;

endmodule

`default_nettype wire

// ==== logic/local_history_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module local_history_table (
    input  wire                     clk,
    input  wire                     reset,
    input  wire [`BP_BHT_INDEX-1:0] rindex,
    input  wire [`BP_BHT_INDEX-1:0] windex,
    input  wire                     load,
    input  wire                     in,
    output bp_pkg::history_t        out
);

    localparam int entries = 2 ** `BP_BHT_INDEX;

    bp_pkg::history_t histories [entries];

    // newest outcome enters at bit 0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < entries; i++) begin
                histories[i] <= '0;
            end
        end else if (load) begin
            histories[windex] <= {histories[windex][`BP_HISTORY_DEPTH-2:0], in};
        end
    end

    assign out = histories[rindex];

endmodule

`default_nettype wire

// ==== logic/pattern_history_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_history_table #(
    parameter int index_width = 4
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire [index_width-1:0] rindex,
    input  wire [index_width-1:0] windex,
    input  wire                   increment,
    input  wire                   decrement,
    output logic                  out
);

    localparam int entries = 2 ** index_width;

    logic [1:0] counters [entries];
    logic [1:0] current;

    assign current = counters[windex];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < entries; i++) begin
                counters[i] <= 2'b01; // weakly not taken
            end
        end else begin
            if (increment) begin
                if (current != 2'b11) begin
                    counters[windex] <= current + 2'd1;
                end
            end else if (decrement) begin
                if (current != 2'b00) begin
                    counters[windex] <= current - 2'd1;
                end
            end
        end
    end

    assign out = counters[rindex][1]; // upper bit is the prediction

endmodule

`default_nettype wire

// ==== logic/perf_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module perf_counter #(
    parameter int width = 8
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              count,
    output logic [width-1:0] value,
    output logic             overflow
);

    always_ff @(posedge clk) begin
        if (reset) begin
            value    <= '0;
            overflow <= 1'b0;
        end else if (count) begin
            value <= value + 1'b1; // wraps to zero past max
            if (&value) begin
                overflow <= 1'b1; // sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/prediction_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module prediction_stats (
    input  wire                   clk,
    input  wire                   reset,
    input  wire bp_pkg::resolve_t resolve,
    output bp_pkg::perf_stats_t   stats
);

    logic                      cf_event;
    logic                      correct_event;
    logic [`BP_PERF_WIDTH-1:0] cf_count;
    logic                      cf_overflow;
    logic [`BP_PERF_WIDTH-1:0] correct_count;
    logic                      correct_overflow;

    assign cf_event = resolve.valid; // every resolved br, jal, jalr

    // only conditional branches score direction accuracy
    assign correct_event = resolve.valid
                        && (resolve.kind == bp_pkg::br)
                        && (resolve.taken == resolve.pred.taken);

    perf_counter #(.width(`BP_PERF_WIDTH)) cf_counter (
        .clk(clk),
        .reset(reset),
        .count(cf_event),
        .value(cf_count),
        .overflow(cf_overflow)
    );

    perf_counter #(.width(`BP_PERF_WIDTH)) correct_counter (
        .clk(clk),
        .reset(reset),
        .count(correct_event),
        .value(correct_count),
        .overflow(correct_overflow)
    );

    always_comb begin
        stats.control_flow_count    = cf_count;
        stats.control_flow_overflow = cf_overflow;
        stats.correct_count         = correct_count;
        stats.correct_overflow      = correct_overflow;
    end

endmodule

`default_nettype wire

// ==== logic/tournament_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module tournament_predictor (
    input  wire                   clk,
    input  wire                   reset,
    input  wire bp_pkg::word_t    fetch_pc,
    input  wire bp_pkg::resolve_t resolve,
    output logic                  taken,
    output logic                  local_pr,
    output logic                  global_pr,
    output bp_pkg::history_t      global_index,
    output bp_pkg::history_t      local_index
);

    bp_pkg::history_t ghr;
    bp_pkg::history_t bht_out;
    logic             use_global;
    logic             is_br;
    logic             pht_increment;
    logic             pht_decrement;
    logic             global_right;
    logic             local_right;
    logic             chooser_increment;
    logic             chooser_decrement;

    assign is_br         = resolve.valid && (resolve.kind == bp_pkg::br);
    assign pht_increment = is_br && resolve.taken;
    assign pht_decrement = is_br && !resolve.taken;

    // chooser trains only when the two predictors disagree on correctness
    assign global_right      = resolve.pred.global_pr == resolve.taken;
    assign local_right       = resolve.pred.local_pr == resolve.taken;
    assign chooser_increment = is_br && global_right && !local_right;
    assign chooser_decrement = is_br && local_right && !global_right;

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (is_br) begin
            ghr <= {ghr[`BP_HISTORY_DEPTH-2:0], resolve.taken}; // newest at bit 0
        end
    end

    pattern_history_table #(.index_width(`BP_HISTORY_DEPTH)) global_pht (
        .clk(clk),
        .reset(reset),
        .rindex(ghr),
        .windex(resolve.pred.global_index), // history used at fetch
        .increment(pht_increment),
        .decrement(pht_decrement),
        .out(global_pr)
    );

    local_history_table bht (
        .clk(clk),
        .reset(reset),
        .rindex(fetch_pc[`BP_BHT_INDEX+1:2]),
        .windex(resolve.pc[`BP_BHT_INDEX+1:2]),
        .load(is_br),
        .in(resolve.taken),
        .out(bht_out)
    );

    pattern_history_table #(.index_width(`BP_HISTORY_DEPTH)) local_pht (
        .clk(clk),
        .reset(reset),
        .rindex(bht_out),
        .windex(resolve.pred.local_index),
        .increment(pht_increment),
        .decrement(pht_decrement),
        .out(local_pr)
    );

    pattern_history_table #(.index_width(`BP_CHOOSER_INDEX)) chooser_pht (
        .clk(clk),
        .reset(reset),
        .rindex(fetch_pc[`BP_CHOOSER_INDEX+1:2]),
        .windex(resolve.pc[`BP_CHOOSER_INDEX+1:2]),
        .increment(chooser_increment),
        .decrement(chooser_decrement),
        .out(use_global)
    );

    assign taken        = use_global ? global_pr : local_pr; // 1 picks global
    assign global_index = ghr;
    assign local_index  = bht_out;

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/bp_pkg.sv
logic/pattern_history_table.sv
logic/local_history_table.sv
logic/branch_target_buffer.sv
logic/tournament_predictor.sv
logic/perf_counter.sv
logic/prediction_stats.sv
logic/branch_predictor.sv
tests/branch_predictor_tb.sv

// ==== tests/branch_predictor_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module branch_predictor_tb;

    localparam int pool_size     = 24;
    localparam int random_cycles = 420;
    localparam int steady_cycles = 300;
    localparam int wait_limit    = 32;

    typedef logic [`BP_PERF_WIDTH-1:0] count_t;

    logic                clk;
    logic                reset;
    bp_pkg::word_t       fetch_pc;
    bp_pkg::resolve_t    resolve;
    bp_pkg::prediction_t prediction;
    bp_pkg::perf_stats_t stats;

    logic [1:0]          global_pht [2 ** `BP_HISTORY_DEPTH];
    logic [1:0]          local_pht [2 ** `BP_HISTORY_DEPTH];
    logic [1:0]          chooser [2 ** `BP_CHOOSER_INDEX];
    bp_pkg::history_t    bht [2 ** `BP_BHT_INDEX];
    bp_pkg::history_t    ghr;
    logic                btb_valid [2 ** `BP_BTB_INDEX];
    bp_pkg::word_t       btb_pc [2 ** `BP_BTB_INDEX]; // tag comes from the stored pc
    bp_pkg::cf_kind_t    btb_kind [2 ** `BP_BTB_INDEX];
    bp_pkg::word_t       btb_target [2 ** `BP_BTB_INDEX];
    bp_pkg::perf_stats_t model_stats;
    bp_pkg::word_t       pc_pool [pool_size];
    integer              seed;

    branch_predictor uut (
        .clk(clk),
        .reset(reset),
        .fetch_pc(fetch_pc),
        .resolve(resolve),
        .prediction(prediction),
        .stats(stats)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_prediction(input bp_pkg::prediction_t got,
                                    input bp_pkg::prediction_t exp);
        if (got.btb_hit !== exp.btb_hit) begin
            report_mismatch("prediction.btb_hit", 32'(got.btb_hit), 32'(exp.btb_hit));
        end
        if (exp.btb_hit) begin // entry contents only mean something on a hit
            if (got.kind !== exp.kind) begin
                report_mismatch("prediction.kind", 32'(got.kind), 32'(exp.kind));
            end
            if (got.target !== exp.target) begin
                report_mismatch("prediction.target", got.target, exp.target);
            end
        end
        if (got.taken !== exp.taken) begin
            report_mismatch("prediction.taken", 32'(got.taken), 32'(exp.taken));
        end
        if (got.local_pr !== exp.local_pr) begin
            report_mismatch("prediction.local_pr", 32'(got.local_pr), 32'(exp.local_pr));
        end
        if (got.global_pr !== exp.global_pr) begin
            report_mismatch("prediction.global_pr", 32'(got.global_pr), 32'(exp.global_pr));
        end
        if (got.global_index !== exp.global_index) begin
            report_mismatch("prediction.global_index", 32'(got.global_index),
                            32'(exp.global_index));
        end
        if (got.local_index !== exp.local_index) begin
            report_mismatch("prediction.local_index", 32'(got.local_index),
                            32'(exp.local_index));
        end
        if (got.next_pc !== exp.next_pc) begin
            report_mismatch("prediction.next_pc", got.next_pc, exp.next_pc);
        end
    endtask

    task automatic check_stats(input bp_pkg::perf_stats_t got, input bp_pkg::perf_stats_t exp);
        if (got.control_flow_count !== exp.control_flow_count) begin
            report_mismatch("stats.control_flow_count", 32'(got.control_flow_count),
                            32'(exp.control_flow_count));
        end
        if (got.control_flow_overflow !== exp.control_flow_overflow) begin
            report_mismatch("stats.control_flow_overflow", 32'(got.control_flow_overflow),
                            32'(exp.control_flow_overflow));
        end
        if (got.correct_count !== exp.correct_count) begin
            report_mismatch("stats.correct_count", 32'(got.correct_count),
                            32'(exp.correct_count));
        end
        if (got.correct_overflow !== exp.correct_overflow) begin
            report_mismatch("stats.correct_overflow", 32'(got.correct_overflow),
                            32'(exp.correct_overflow));
        end
    endtask

    function automatic logic [1:0] saturate_step(input logic [1:0] ctr, input logic up);
        if (up) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'd1;
    endfunction

    function automatic bp_pkg::prediction_t expected_prediction(input bp_pkg::word_t pc);
        bp_pkg::prediction_t      p;
        logic [`BP_BTB_INDEX-1:0] slot;
        logic                     redirect;
        slot = pc[`BP_BTB_INDEX+1:2];
        p.btb_hit = btb_valid[slot]
                 && (btb_pc[slot][`BP_XLEN-1:`BP_BTB_INDEX+2] == pc[`BP_XLEN-1:`BP_BTB_INDEX+2]);
        p.kind         = btb_kind[slot];
        p.target       = btb_target[slot];
        p.global_index = ghr;
        p.local_index  = bht[pc[`BP_BHT_INDEX+1:2]];
        p.global_pr    = global_pht[ghr][1];
        p.local_pr     = local_pht[p.local_index][1];
        p.taken        = chooser[pc[`BP_CHOOSER_INDEX+1:2]][1] ? p.global_pr : p.local_pr;
        redirect = p.btb_hit && ((p.kind == bp_pkg::jal) || (p.kind == bp_pkg::jalr)
                              || ((p.kind == bp_pkg::br) && p.taken));
        p.next_pc = redirect ? p.target : pc + 32'd4;
        return p;
    endfunction

    task automatic update_model(input bp_pkg::resolve_t r);
        logic [`BP_BTB_INDEX-1:0]     slot;
        logic [`BP_BHT_INDEX-1:0]     bht_slot;
        logic [`BP_CHOOSER_INDEX-1:0] choice_slot;
        logic                         global_ok;
        logic                         local_ok;
        if (r.valid) begin
            slot        = r.pc[`BP_BTB_INDEX+1:2];
            bht_slot    = r.pc[`BP_BHT_INDEX+1:2];
            choice_slot = r.pc[`BP_CHOOSER_INDEX+1:2];
            btb_valid[slot]  = 1'b1;
            btb_pc[slot]     = r.pc;
            btb_kind[slot]   = r.kind;
            btb_target[slot] = r.target;
            if (r.kind == bp_pkg::jalr) begin
                btb_target[slot][0] = 1'b0;
            end
            if (r.kind == bp_pkg::br) begin
                global_pht[r.pred.global_index] =
                    saturate_step(global_pht[r.pred.global_index], r.taken);
                local_pht[r.pred.local_index] =
                    saturate_step(local_pht[r.pred.local_index], r.taken);
                ghr           = {ghr[`BP_HISTORY_DEPTH-2:0], r.taken};
                bht[bht_slot] = {bht[bht_slot][`BP_HISTORY_DEPTH-2:0], r.taken};
                global_ok = (r.pred.global_pr == r.taken);
                local_ok  = (r.pred.local_pr == r.taken);
                if (global_ok && !local_ok) begin
                    chooser[choice_slot] = saturate_step(chooser[choice_slot], 1'b1);
                end else if (local_ok && !global_ok) begin
                    chooser[choice_slot] = saturate_step(chooser[choice_slot], 1'b0);
                end
                if (r.taken == r.pred.taken) begin
                    model_stats.correct_overflow |= &model_stats.correct_count;
                    model_stats.correct_count = model_stats.correct_count + count_t'(1);
                end
            end
            model_stats.control_flow_overflow |= &model_stats.control_flow_count;
            model_stats.control_flow_count = model_stats.control_flow_count + count_t'(1);
        end
    endtask

    // one fetch, optionally resolving the same pc with the model's prediction
    task automatic run_cycle(input bp_pkg::word_t pc, input logic valid,
                             input bp_pkg::cf_kind_t kind, input logic taken,
                             input bp_pkg::word_t target);
        bp_pkg::prediction_t exp;
        bp_pkg::resolve_t    r;
        @(negedge clk);
        exp      = expected_prediction(pc);
        r.valid  = valid;
        r.pc     = pc;
        r.kind   = kind;
        r.taken  = taken;
        r.target = target;
        r.pred   = exp;
        fetch_pc = pc;
        resolve  = r;
        #1;
        check_prediction(prediction, exp);
        check_stats(stats, model_stats);
        @(posedge clk);
        update_model(r);
    endtask

    initial begin
        int                cycles;
        int                pick;
        logic [31:0]       raw;
        logic              valid_bit;
        logic              taken_bit;
        bp_pkg::cf_kind_t  kind;
        seed     = 83;
        clk      = 1'b0;
        reset    = 1'b1;
        fetch_pc = '0;
        resolve  = '0;
        ghr         = '0;
        model_stats = '0;
        for (int i = 0; i < 2 ** `BP_HISTORY_DEPTH; i++) begin
            global_pht[i] = 2'b01;
            local_pht[i]  = 2'b01;
        end
        for (int i = 0; i < 2 ** `BP_CHOOSER_INDEX; i++) begin
            chooser[i] = 2'b01;
        end
        for (int i = 0; i < 2 ** `BP_BHT_INDEX; i++) begin
            bht[i] = '0;
        end
        for (int i = 0; i < 2 ** `BP_BTB_INDEX; i++) begin
            btb_valid[i]  = 1'b0;
            btb_pc[i]     = '0;
            btb_kind[i]   = bp_pkg::br;
            btb_target[i] = '0;
        end
        // pc i and i+12 share every index, bit 6 changes the tag
        for (int i = 0; i < pool_size; i++) begin
            pc_pool[i] = 32'h0000_1000 + 32'((i % 12) * 4) + 32'((i / 12) * 32'h40);
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset  = 1'b0;
        cycles = 0;
        while (!((stats == '0) && (prediction.next_pc == fetch_pc + 32'd4))) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("DUT did not come out of reset with cleared state");
            end
        end

        for (int i = 0; i < pool_size; i++) begin
            run_cycle(pc_pool[i], 1'b0, bp_pkg::br, 1'b0, '0); // cold tables fall through
        end

        repeat (10) run_cycle(pc_pool[3], 1'b1, bp_pkg::br, 1'b1, 32'h0000_1400);
        run_cycle(pc_pool[3], 1'b1, bp_pkg::br, 1'b0, 32'h0000_1400); // one step back
        // four more takens bring both histories back to the saturated slot
        repeat (4) run_cycle(pc_pool[3], 1'b1, bp_pkg::br, 1'b1, 32'h0000_1400);
        run_cycle(pc_pool[3], 1'b0, bp_pkg::br, 1'b0, '0);

        run_cycle(pc_pool[5], 1'b1, bp_pkg::jalr, 1'b0, 32'h0000_2345);
        run_cycle(pc_pool[5], 1'b0, bp_pkg::br, 1'b0, '0);
        run_cycle(pc_pool[17], 1'b0, bp_pkg::br, 1'b0, '0); // alias, other tag
        run_cycle(pc_pool[9], 1'b1, bp_pkg::jal, 1'b1, 32'h0000_3000);
        run_cycle(pc_pool[9], 1'b0, bp_pkg::br, 1'b0, '0);

        for (int n = 0; n < random_cycles; n++) begin
            raw       = $random(seed);
            pick      = int'(raw % 32'(pool_size));
            raw       = $random(seed);
            kind      = bp_pkg::cf_kind_t'(2'(raw % 32'd3));
            raw       = $random(seed);
            valid_bit = (raw[2:0] != 3'b000); // mostly resolving
            taken_bit = raw[8];
            raw       = $random(seed);
            run_cycle(pc_pool[pick], valid_bit, kind, taken_bit, raw);
        end

        // steady not-taken branch, predicted right once its counters settle
        repeat (steady_cycles) run_cycle(pc_pool[0], 1'b1, bp_pkg::br, 1'b0, '0);

        @(negedge clk);
        fetch_pc = pc_pool[0];
        resolve  = '0;
        cycles   = 0;
        while (stats !== model_stats) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("statistics did not settle after the last resolve");
            end
        end
        check_stats(stats, model_stats);

        if (model_stats.control_flow_overflow && model_stats.correct_overflow) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run("run ended before both statistics counters wrapped");
        end
    end

endmodule

`default_nettype wire
